//--- EntryStateFsm.sv
// Per-entry Free/Waiting/Executing state and free-entry allocation.
// allocEntry is the lowest Free entry and is only valid while dispatchReady is high.
// An entry freed by wakeup can be allocated again in the next cycle.
`timescale 1ns/10ps
`default_nettype none

module EntryStateFsm (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 dispatchFire,
    input  logic                 issueFire,
    input  SchedPkg::EntryIndex  issueEntry,
    input  SchedPkg::EntryVector wakeupVector,
    output logic                 dispatchReady,
    output SchedPkg::EntryIndex  allocEntry,
    output SchedPkg::EntryVector waitingMask
);
    import SchedPkg::*;

    EntryState [EntryNum-1:0] state;
    EntryVector               freeMask;
    EntryVector               executingMask;

    always_comb begin
        for (int i = 0; i < EntryNum; i++) begin
            freeMask[i]      = (state[i] == Free);
            waitingMask[i]   = (state[i] == Waiting);
            executingMask[i] = (state[i] == Executing);
        end
        dispatchReady = |freeMask;
        allocEntry    = lowestIndex(freeMask);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < EntryNum; i++) begin
                state[i] <= Free;
            end
        end else begin
            for (int i = 0; i < EntryNum; i++) begin
                case (state[i])
                    Free: begin
                        if (dispatchFire && allocEntry == EntryIndex'(i)) begin
                            state[i] <= Waiting;
                        end
                    end
                    Waiting: begin
                        if (issueFire && issueEntry == EntryIndex'(i)) begin
                            state[i] <= Executing;
                        end
                    end
                    Executing: begin
                        // Done in the cycle the timer expires.
                        if (wakeupVector[i]) begin
                            state[i] <= Free;
                        end
                    end
                    default: begin
                        state[i] <= Free;
                    end
                endcase
            end
        end
    end

    issueFromWaiting: assert property (
        @(posedge clk) disable iff (rst)
        issueFire |-> waitingMask[issueEntry]
    );

    // Timer and state must agree on which entries are in flight.
    wakeupOnlyExecuting: assert property (
        @(posedge clk) disable iff (rst)
        (wakeupVector & ~executingMask) == '0
    );

endmodule : EntryStateFsm

`default_nettype wire

//--- IssueScheduler.f
OpPkg.sv
SchedPkg.sv
ProducerMatrix.sv
ReadyTable.sv
EntryStateFsm.sv
LatencyTimer.sv
IssueSelect.sv
IssueScheduler.sv
IssueSchedulerTb.sv

//--- IssueScheduler.sv
// Top level of the 8-entry issue scheduler, one dispatch and one issue per cycle.
// completeMask has no back-pressure and lasts exactly one cycle per operation.
// The payload store keeps each dispatched op until its entry is reused.
`timescale 1ns/10ps
`default_nettype none

module IssueScheduler (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 dispatchValid,
    input  SchedPkg::DispatchReq dispatchReq,
    output logic                 dispatchReady,
    output logic                 issueValid,
    input  logic                 issueReady,
    output SchedPkg::IssueGrant  issueGrant,
    output SchedPkg::EntryVector completeMask
);
    import SchedPkg::*;

    logic                     dispatchFire;
    logic                     issueFire;
    EntryIndex                allocEntry;
    SrcInfo                   srcInfo;
    EntryVector               opReady;
    EntryVector               waitingMask;
    EntryVector               wakeupVector;
    DispatchReq [EntryNum-1:0] entryOps;

    assign dispatchFire = dispatchValid && dispatchReady;
    assign completeMask = wakeupVector;

    // Payload store.
    always_ff @(posedge clk) begin
        if (dispatchFire) begin
            entryOps[allocEntry] <= dispatchReq;
        end
    end

    ReadyTable readyTable_i (
        .clk(clk), .rst(rst), .dispatchFire(dispatchFire), .dispatchOp(dispatchReq.op),
        .allocEntry(allocEntry), .wakeupVector(wakeupVector), .srcInfo(srcInfo)
    );

    ProducerMatrix producerMatrix_i (
        .clk(clk), .rst(rst), .dispatchFire(dispatchFire), .allocEntry(allocEntry),
        .srcInfo(srcInfo), .wakeupVector(wakeupVector), .opReady(opReady)
    );

    EntryStateFsm entryStateFsm_i (
        .clk(clk), .rst(rst), .dispatchFire(dispatchFire), .issueFire(issueFire),
        .issueEntry(issueGrant.entry), .wakeupVector(wakeupVector),
        .dispatchReady(dispatchReady), .allocEntry(allocEntry), .waitingMask(waitingMask)
    );

    IssueSelect issueSelect_i (
        .clk(clk), .rst(rst), .waitingMask(waitingMask), .opReady(opReady),
        .entryOps(entryOps), .issueValid(issueValid), .issueReady(issueReady),
        .issueGrant(issueGrant), .issueFire(issueFire)
    );

    LatencyTimer latencyTimer_i (
        .clk(clk), .rst(rst), .issueFire(issueFire), .issueEntry(issueGrant.entry),
        .issueOp(issueGrant.op), .wakeupVector(wakeupVector)
    );

endmodule : IssueScheduler

`default_nettype wire

//--- IssueSchedulerTb.sv
// Testbench for the issue scheduler, run from the project root to find issuePatterns.txt.
// A reference model of entries, producers and latencies is checked at every falling edge.
`timescale 1ns/10ps
`default_nettype none

module IssueSchedulerTb;
    import OpPkg::*;
    import SchedPkg::*;

    localparam int PatternNum = 14;
    localparam int ReadyTimeout = 64;
    localparam int DrainTimeout = 200;

    logic clk;
    logic rst;
    logic dispatchValid;
    DispatchReq dispatchReq;
    logic dispatchReady;
    logic issueValid;
    logic issueReady;
    IssueGrant issueGrant;
    EntryVector completeMask;

    logic [27:0] patterns [0:PatternNum-1];
    logic [31:0] rnd;
    logic [3:0] curStall;
    int cycle;
    logic aborted;
    // Reference model, per entry and per opId.
    logic entryBusy [EntryNum];
    logic entryIssued [EntryNum];
    logic [7:0] entryOp [EntryNum];
    int doneAt [EntryNum];
    OpWord opWord [256];
    int dispCycle [256];
    logic [7:0] prod [256][2];
    logic prodValid [256][2];
    logic issuedFlag [256];
    logic doneFlag [256];
    int doneCycle [256];
    logic [7:0] regWriter [RegNum];
    logic regHasWriter [RegNum];
    logic prevStall;
    IssueGrant heldExp;
    int doneCount;
    logic queueFilled;
    int grantErrors;
    int completeErrors;
    int flagErrors;
    int otherErrors;

    IssueScheduler IssueScheduler_i (
        .clk(clk), .rst(rst), .dispatchValid(dispatchValid), .dispatchReq(dispatchReq),
        .dispatchReady(dispatchReady), .issueValid(issueValid), .issueReady(issueReady),
        .issueGrant(issueGrant), .completeMask(completeMask)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        if (rst) begin
            cycle <= 0;
        end else begin
            cycle <= cycle + 1;
        end
    end

    // A new phase's stall pattern takes effect from the next cycle.
    always @(posedge clk) begin : readyDriver
        logic [3:0] stall;
        stall = curStall;
        #5;
        issueReady = stall[cycle[1:0]];
    end

    function automatic logic [31:0] nextRandom(logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic checkGrant(IssueGrant got, IssueGrant exp);
        if (got !== exp) begin
            $display("Mismatch issueGrant at cycle %0d: got %h expected %h", cycle, got, exp);
            grantErrors++;
        end
    endtask

    task automatic checkComplete(EntryVector got, EntryVector exp);
        if (got !== exp) begin
            $display("Mismatch completeMask at cycle %0d: got %h expected %h", cycle, got, exp);
            completeErrors++;
        end
    endtask

    task automatic checkFlag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("Mismatch %s at cycle %0d: got %h expected %h", name, cycle, got, exp);
            flagErrors++;
        end
    endtask

    // Waiting, dispatched earlier, and every producer done in an earlier cycle.
    function automatic logic isEligible(int e);
        logic [7:0] id;
        logic ok;
        id = entryOp[e];
        ok = entryBusy[e] && !entryIssued[e] && dispCycle[id] < cycle;
        for (int s = 0; s < 2; s++) begin
            if (prodValid[id][s] && !(doneFlag[prod[id][s]] && doneCycle[prod[id][s]] < cycle)) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    task automatic recordDispatch(int e);
        logic [7:0] id;
        OpWord op;
        RegIndex src [2];
        id = dispatchReq.opId;
        op = dispatchReq.op;
        entryBusy[e] = 1'b1;
        entryIssued[e] = 1'b0;
        entryOp[e] = id;
        opWord[id] = op;
        dispCycle[id] = cycle;
        src[0] = op.alu.src1;
        src[1] = op.alu.src2;
        // Sources are looked up before the destination is claimed.
        for (int s = 0; s < 2; s++) begin
            prodValid[id][s] = (op.alu.kind == AluOp) && regHasWriter[src[s]];
            prod[id][s] = regWriter[src[s]];
        end
        regWriter[op.alu.dst] = id;
        regHasWriter[op.alu.dst] = 1'b1;
    endtask

    always @(negedge clk) begin : monitor
        logic anyFree;
        int freeEntry;
        int pick;
        logic expValid;
        IssueGrant expGrant;
        EntryVector expMask;
        logic [7:0] id;
        if (!rst) begin
            anyFree = 1'b0;
            freeEntry = 0;
            for (int e = EntryNum - 1; e >= 0; e--) begin
                if (!entryBusy[e]) begin
                    anyFree = 1'b1;
                    freeEntry = e;
                end
            end
            checkFlag("dispatchReady", dispatchReady, anyFree);
            if (!anyFree) queueFilled = 1'b1;
            if (dispatchValid && anyFree) recordDispatch(freeEntry);

            pick = -1;
            expGrant = heldExp;
            if (prevStall) begin
                pick = int'(heldExp.entry);
            end else begin
                for (int e = EntryNum - 1; e >= 0; e--) begin
                    if (isEligible(e)) pick = e;
                end
                if (pick >= 0) begin
                    expGrant.opId = entryOp[pick];
                    expGrant.entry = EntryIndex'(pick);
                    expGrant.op = opWord[entryOp[pick]];
                end
            end
            expValid = (pick >= 0);
            checkFlag("issueValid", issueValid, expValid);
            if (expValid) checkGrant(issueGrant, expGrant);
            if (expValid && issueReady) begin
                id = entryOp[pick];
                entryIssued[pick] = 1'b1;
                issuedFlag[id] = 1'b1;
                doneAt[pick] = cycle + ((opWord[id].alu.kind == AluOp) ?
                               int'(opWord[id].alu.latency) : 1);
            end
            prevStall = expValid && !issueReady;
            heldExp = expGrant;

            expMask = '0;
            for (int e = 0; e < EntryNum; e++) begin
                expMask[e] = entryBusy[e] && entryIssued[e] && doneAt[e] == cycle;
            end
            checkComplete(completeMask, expMask);
            for (int e = 0; e < EntryNum; e++) begin
                if (expMask[e]) begin
                    doneFlag[entryOp[e]] = 1'b1;
                    doneCycle[entryOp[e]] = cycle;
                    doneCount++;
                    entryBusy[e] = 1'b0;
                end
            end
        end
    end

    task automatic driveOp(int k);
        int waited;
        logic [27:0] pat;
        pat = patterns[k];
        rnd = nextRandom(rnd);
        repeat (rnd[16]) begin
            @(posedge clk);
            #5;
        end
        dispatchValid = 1'b1;
        dispatchReq = DispatchReq'(pat[27:4]);
        curStall = pat[3:0];
        waited = 0;
        @(negedge clk);
        while (!dispatchReady && waited < ReadyTimeout) begin
            @(negedge clk);
            waited++;
        end
        if (!dispatchReady) begin
            $display("Dispatch never became ready for opId %h", pat[27:20]);
            otherErrors++;
            aborted = 1'b1;
        end
        @(posedge clk);
        #5;
        dispatchValid = 1'b0;
    endtask

    task automatic waitDrain();
        int waited;
        waited = 0;
        while (doneCount < PatternNum && waited < DrainTimeout) begin
            @(negedge clk);
            waited++;
        end
        if (doneCount < PatternNum) begin
            $display("Not every operation completed before the drain timeout");
            otherErrors++;
        end
    endtask

    initial begin
        int total;
        clk = 1'b0;
        rst = 1'b1;
        dispatchValid = 1'b0;
        dispatchReq = '0;
        issueReady = 1'b0;
        curStall = 4'hF;
        aborted = 1'b0;
        prevStall = 1'b0;
        heldExp = '0;
        doneCount = 0;
        queueFilled = 1'b0;
        grantErrors = 0;
        completeErrors = 0;
        flagErrors = 0;
        otherErrors = 0;
        for (int e = 0; e < EntryNum; e++) begin
            entryBusy[e] = 1'b0;
            entryIssued[e] = 1'b0;
            entryOp[e] = '0;
            doneAt[e] = -1;
        end
        for (int i = 0; i < 256; i++) begin
            issuedFlag[i] = 1'b0;
            doneFlag[i] = 1'b0;
            prodValid[i][0] = 1'b0;
            prodValid[i][1] = 1'b0;
        end
        for (int r = 0; r < RegNum; r++) begin
            regHasWriter[r] = 1'b0;
            regWriter[r] = '0;
        end
        $readmemh("issuePatterns.txt", patterns);
        rnd = 32'h7a12cb6f;
        repeat (4) @(posedge clk);
        #5;
        rst = 1'b0;

        for (int k = 0; k < PatternNum; k++) begin
            if (!aborted) driveOp(k);
        end
        // Let everything still queued issue freely.
        curStall = 4'hF;
        waitDrain();

        for (int k = 0; k < PatternNum; k++) begin
            if (!issuedFlag[patterns[k][27:20]] || !doneFlag[patterns[k][27:20]]) begin
                $display("opId %h was not issued and completed", patterns[k][27:20]);
                otherErrors++;
            end
        end
        if (!queueFilled) begin
            $display("The queue never became full, so dispatch back-pressure went untested");
            otherErrors++;
        end

        total = grantErrors + completeErrors + flagErrors + otherErrors;
        $display("Errors: grant %0d, complete %0d, flag %0d, other %0d",
                 grantErrors, completeErrors, flagErrors, otherErrors);
        if (total == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule : IssueSchedulerTb

`default_nettype wire

//--- IssueSelect.sv
// Lowest-index select among waiting and ready entries.
// Once offered, the grant is held unchanged until issueReady accepts it,
// even if a lower entry becomes eligible meanwhile.
`timescale 1ns/10ps
`default_nettype none

module IssueSelect (
    input  logic                                  clk,
    input  logic                                  rst,
    input  SchedPkg::EntryVector                  waitingMask,
    input  SchedPkg::EntryVector                  opReady,
    input  SchedPkg::DispatchReq [SchedPkg::EntryNum-1:0] entryOps,
    output logic                                  issueValid,
    input  logic                                  issueReady,
    output SchedPkg::IssueGrant                   issueGrant,
    output logic                                  issueFire
);
    import SchedPkg::*;

    EntryVector candidates;
    EntryIndex  pick;
    IssueGrant  freshGrant;
    IssueGrant  heldGrant;
    logic       heldValid;

    always_comb begin
        candidates       = waitingMask & opReady;
        pick             = lowestIndex(candidates);
        freshGrant.opId  = entryOps[pick].opId;
        freshGrant.entry = pick;
        freshGrant.op    = entryOps[pick].op;

        if (heldValid) begin
            issueValid = 1'b1;
            issueGrant = heldGrant;
        end else begin
            issueValid = |candidates;
            issueGrant = freshGrant;
        end
        issueFire = issueValid && issueReady;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            heldValid <= 1'b0;
        end else begin
            heldValid <= issueValid && !issueReady;
        end
        heldGrant <= issueGrant;
    end

    // A held offer must still name a waiting, ready entry with its stored payload.
    stableGrant: assert property (
        @(posedge clk) disable iff (rst)
        issueValid && !issueReady |=> issueValid && $stable(issueGrant)
            && waitingMask[issueGrant.entry]
            && opReady[issueGrant.entry]
            && issueGrant.opId == entryOps[issueGrant.entry].opId
            && issueGrant.op == entryOps[issueGrant.entry].op
    );

endmodule : IssueSelect

`default_nettype wire

//--- LatencyTimer.sv
// Per-entry latency countdown.
// A counter is loaded with the latency at issue and reports wakeup while it is one.
// Immediate forms count as latency one. Several entries may expire together.
`timescale 1ns/10ps
`default_nettype none

module LatencyTimer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issueFire,
    input  SchedPkg::EntryIndex  issueEntry,
    input  OpPkg::OpWord         issueOp,
    output SchedPkg::EntryVector wakeupVector
);
    import OpPkg::*;
    import SchedPkg::*;

    logic [EntryNum-1:0][2:0] count;
    logic [2:0]               loadValue;

    always_comb begin
        if (issueOp.alu.kind == AluOp) begin
            loadValue = issueOp.alu.latency;
        end else begin
            loadValue = 3'd1;
        end

        for (int i = 0; i < EntryNum; i++) begin
            wakeupVector[i] = (count[i] == 3'd1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            for (int i = 0; i < EntryNum; i++) begin
                if (issueFire && issueEntry == EntryIndex'(i)) begin
                    count[i] <= loadValue;
                end else if (count[i] != 3'd0) begin
                    // Idles at zero after the wakeup cycle.
                    count[i] <= count[i] - 3'd1;
                end
            end
        end
    end

    // An entry is only issued again after its previous run has freed it.
    noBusyLoad: assert property (
        @(posedge clk) disable iff (rst)
        issueFire |-> count[issueEntry] == 3'd0
    );

endmodule : LatencyTimer

`default_nettype wire

//--- OpPkg.sv
// Operation-word encoding shared by dispatch, issue and timing logic.
// Every word is 16 bits; the kind bit and dst sit at the same place in both forms.
// ALU latency of 0 is illegal and is not caught here.
`default_nettype none

package OpPkg;

    localparam int RegNum = 16;

    typedef logic [3:0] RegIndex;

    typedef enum logic {
        AluOp = 1'b0,
        ImmOp = 1'b1
    } OpKind;

    // Register-to-register form with a fixed execution latency.
    typedef struct packed {
        OpKind      kind;
        RegIndex    dst;
        RegIndex    src1;
        RegIndex    src2;
        logic [2:0] latency;
    } AluForm;

    // Immediate form, no sources, latency of one.
    typedef struct packed {
        OpKind       kind;
        RegIndex     dst;
        logic [10:0] imm;
    } ImmForm;

    typedef union packed {
        AluForm alu;
        ImmForm imm;
    } OpWord;

endpackage : OpPkg

`default_nettype wire

//--- ProducerMatrix.sv
// Producer dependency matrix for the issue queue.
// Row i holds the entries that entry i still waits on.
// opReady follows the registered matrix, so a wakeup frees consumers one cycle later.
// Rows of non-waiting entries are meaningless and are masked outside.
`timescale 1ns/10ps
`default_nettype none

module ProducerMatrix (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 dispatchFire,
    input  SchedPkg::EntryIndex  allocEntry,
    input  SchedPkg::SrcInfo     srcInfo,
    input  SchedPkg::EntryVector wakeupVector,
    output SchedPkg::EntryVector opReady
);
    import SchedPkg::*;

    EntryVector [EntryNum-1:0] matrix;
    EntryVector [EntryNum-1:0] nextMatrix;
    EntryVector                dispatchRow;

    always_comb begin
        // Column per source that is still pending.
        dispatchRow = '0;
        for (int s = 0; s < 2; s++) begin
            if (!srcInfo.srcReady[s]) begin
                dispatchRow[srcInfo.srcPtr[s]] = 1'b1;
            end
        end

        for (int i = 0; i < EntryNum; i++) begin
            nextMatrix[i] = matrix[i] & ~wakeupVector;
        end

        // New row replaces whatever the freed entry left behind.
        if (dispatchFire) begin
            nextMatrix[allocEntry] = dispatchRow;
        end

        for (int i = 0; i < EntryNum; i++) begin
            opReady[i] = ~|matrix[i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            matrix <= '0;
        end else begin
            matrix <= nextMatrix;
        end
    end

    // The allocated entry is Free, so no register can name it as a pending producer.
    noSelfDependency: assert property (
        @(posedge clk) disable iff (rst)
        dispatchFire |-> !dispatchRow[allocEntry]
    );

endmodule : ProducerMatrix

`default_nettype wire

//--- ReadyTable.sv
// Register ready table with producer entry per register.
// A wakeup in the dispatch cycle is bypassed into the source readiness.
// Sources are read before the destination update, so dst may equal a source.
// Stale producer pointers of ready registers are harmless.
`timescale 1ns/10ps
`default_nettype none

module ReadyTable (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 dispatchFire,
    input  OpPkg::OpWord         dispatchOp,
    input  SchedPkg::EntryIndex  allocEntry,
    input  SchedPkg::EntryVector wakeupVector,
    output SchedPkg::SrcInfo     srcInfo
);
    import OpPkg::*;
    import SchedPkg::*;

    logic [RegNum-1:0]     regReady;
    EntryIndex [RegNum-1:0] regProducer;
    RegIndex [1:0]         srcReg;
    logic                  hasSources;

    always_comb begin
        srcReg[0]  = dispatchOp.alu.src1;
        srcReg[1]  = dispatchOp.alu.src2;
        hasSources = (dispatchOp.alu.kind == AluOp);

        for (int s = 0; s < 2; s++) begin
            srcInfo.srcPtr[s] = regProducer[srcReg[s]];
            // Immediate forms have no sources at all.
            srcInfo.srcReady[s] = !hasSources
                                  || regReady[srcReg[s]]
                                  || wakeupVector[regProducer[srcReg[s]]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            regReady    <= '1;
            regProducer <= '0;
        end else begin
            for (int r = 0; r < RegNum; r++) begin
                if (wakeupVector[regProducer[r]]) begin
                    regReady[r] <= 1'b1;
                end
            end
            // Dispatch overrides a wakeup of the old producer.
            if (dispatchFire) begin
                regReady[dispatchOp.alu.dst]    <= 1'b0;
                regProducer[dispatchOp.alu.dst] <= allocEntry;
            end
        end
    end

endmodule : ReadyTable

`default_nettype wire

//--- SchedPkg.sv
// Issue queue structures: entry indices, entry vectors, states and port payloads.
// The queue is fixed at 8 entries with 3-bit indices.
`default_nettype none

package SchedPkg;

    localparam int EntryNum = 8;

    typedef logic [2:0] EntryIndex;

    // One bit per entry, used one-hot or multi-hot.
    typedef logic [EntryNum-1:0] EntryVector;

    typedef enum logic [1:0] {
        Free      = 2'd0,
        Waiting   = 2'd1,
        Executing = 2'd2
    } EntryState;

    typedef struct packed {
        logic [7:0]   opId;
        OpPkg::OpWord op;
    } DispatchReq;

    typedef struct packed {
        logic [7:0]   opId;
        EntryIndex    entry;
        OpPkg::OpWord op;
    } IssueGrant;

    // Source readiness and producer entries for the op being dispatched.
    typedef struct packed {
        logic [1:0]            srcReady;
        EntryIndex [1:0]       srcPtr;
    } SrcInfo;

    // Lowest set bit of a vector, zero when none is set.
    function automatic EntryIndex lowestIndex(EntryVector vec);
        EntryIndex idx;
        idx = '0;
        for (int i = EntryNum - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = EntryIndex'(i);
            end
        end
        return idx;
    endfunction

endpackage : SchedPkg

`default_nettype wire

//--- issuePatterns.txt
// Each word: opId (2 hex), OpWord (4 hex), issueReady pattern (1 hex).
// Pattern bit n drives issueReady in cycles where the cycle number mod 4 is n.
010807F
0210879
0318975
04208EE
052A0F3
0630AAF
073A336
0808B9A
09C7FFF
0A4C147
0B54CDB
0C587A5
0DE123D
0E6E09F

//--- run.sh
#!/usr/bin/env bash
# Builds the issue scheduler testbench with Verilator and runs it.
# The run passes only if the log holds the testbench's pass line.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f IssueScheduler.f \
    --top-module IssueSchedulerTb -o simIssue
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simIssue > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" sim.log; then
    exit 0
fi
exit 1
